// File: src/vpu_pkg.sv
package vpu_pkg;

    //////////////////////////////////////////////////////////////////////
    // screen and datapath sizes
    //////////////////////////////////////////////////////////////////////

    // clamp limits for the clipping lanes
    localparam int screen_w = 640;
    localparam int screen_h = 480;

    // unsigned span coordinate widths, 10 and 9 bits
    localparam int x_w = $clog2(screen_w);
    localparam int y_w = $clog2(screen_h);

    // signed command coordinates
    localparam int coord_w = 12;
    localparam int color_w = 3;

    // clipping lanes and round-robin pointer
    localparam int num_lanes  = 4;
    localparam int lane_idx_w = (num_lanes > 1) ? $clog2(num_lanes) : 1;
    localparam logic [lane_idx_w-1:0] last_lane = lane_idx_w'(num_lanes - 1);

    // depth of command and span queues
    localparam int queue_depth = 4;

    //////////////////////////////////////////////////////////////////////
    // command and span formats
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {
        op_draw = 1'b0,
        op_fill = 1'b1
    } vpu_op_e;

    // 52 bits
    typedef struct packed {
        vpu_op_e                   op;
        logic [color_w-1:0]        color;
        logic signed [coord_w-1:0] x0;
        logic signed [coord_w-1:0] y0;
        logic signed [coord_w-1:0] x1;
        logic signed [coord_w-1:0] y1;
    } vpu_cmd_t;

    // 42 bits, corners already ordered and clamped
    typedef struct packed {
        logic [color_w-1:0] color;
        logic [x_w-1:0]     x0;
        logic [x_w-1:0]     x1;
        logic [y_w-1:0]     y0;
        logic [y_w-1:0]     y1;
        logic               visible;
    } vpu_span_t;

endpackage

// File: src/vpu_queue.sv
module vpu_queue import vpu_pkg::*; #(
    parameter type item_t = vpu_cmd_t,
    parameter int  depth  = queue_depth
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    output logic  in_ready,
    input  item_t in_item,
    output logic  out_valid,
    input  logic  out_ready,
    output item_t out_item
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [ptr_w:0]   full_count = (ptr_w + 1)'(depth);
    localparam logic [ptr_w-1:0] last_slot  = ptr_w'(depth - 1);

    item_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != full_count);
    assign out_valid = (count != '0);
    assign out_item  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_item;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + ptr_w'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + ptr_w'(1);
            end
            if (push && !pop) begin
                count <= count + (ptr_w + 1)'(1);
            end else if (pop && !push) begin
                count <= count - (ptr_w + 1)'(1);
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= full_count);

endmodule

// File: src/vpu_cmd_intake.sv
module vpu_cmd_intake import vpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_req,
    input  vpu_cmd_t             cmd,
    output logic                 cmd_ack,
    output logic [color_w-1:0]   bg_color,
    output logic [num_lanes-1:0] lane_in_valid,
    input  logic [num_lanes-1:0] lane_in_ready,
    output vpu_cmd_t             lane_cmd
);

    typedef enum logic {
        st_idle,
        st_ack
    } ack_state_e;

    ack_state_e            state;
    logic                  is_fill;
    logic                  take;
    logic                  q_in_valid;
    logic                  q_in_ready;
    logic                  q_out_valid;
    logic                  q_out_ready;
    vpu_cmd_t              q_out_item;
    logic [lane_idx_w-1:0] disp_ptr;

    //////////////////////////////////////////////////////////////////////
    // four-phase responder
    //////////////////////////////////////////////////////////////////////

    // fill never needs queue room
    assign is_fill    = (cmd.op == op_fill);
    assign take       = (state == st_idle) && cmd_req && (is_fill || q_in_ready);
    assign q_in_valid = take && !is_fill;
    assign cmd_ack    = (state == st_ack);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: if (take) state <= st_ack;
                st_ack:  if (!cmd_req) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // background register, loads on the ack edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bg_color <= '0;
        end else if (take && is_fill) begin
            bg_color <= cmd.color;
        end
    end

    vpu_queue #(
        .item_t (vpu_cmd_t),
        .depth  (queue_depth)
    ) u_cmd_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (q_in_valid),
        .in_ready  (q_in_ready),
        .in_item   (cmd),
        .out_valid (q_out_valid),
        .out_ready (q_out_ready),
        .out_item  (q_out_item)
    );

    //////////////////////////////////////////////////////////////////////
    // round-robin dispatch
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        lane_in_valid           = '0;
        lane_in_valid[disp_ptr] = q_out_valid;
    end

    assign q_out_ready = lane_in_ready[disp_ptr];
    assign lane_cmd    = q_out_item;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            disp_ptr <= '0;
        end else if (q_out_valid && q_out_ready) begin
            disp_ptr <= (disp_ptr == last_lane) ? '0 : disp_ptr + lane_idx_w'(1);
        end
    end

    a_ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> $past(cmd_req));

endmodule

// File: src/vpu_clip_lane.sv
module vpu_clip_lane import vpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    output logic      in_ready,
    input  vpu_cmd_t  in_cmd,
    output logic      out_valid,
    input  logic      out_ready,
    output vpu_span_t out_span
);

    logic                      s1_valid;
    logic                      s2_valid;
    logic [color_w-1:0]        s1_color;
    logic signed [coord_w-1:0] s1_x0;
    logic signed [coord_w-1:0] s1_x1;
    logic signed [coord_w-1:0] s1_y0;
    logic signed [coord_w-1:0] s1_y1;
    vpu_span_t                 s2_span;

    // limit a signed coordinate to 0 .. limit-1
    function automatic logic [coord_w-1:0] clamp(input logic signed [coord_w-1:0] v,
                                                 input int limit);
        logic [coord_w-1:0] r;
        if (v < 0) begin
            r = '0;
        end else if (v > limit - 1) begin
            r = coord_w'(limit - 1);
        end else begin
            r = v;
        end
        return r;
    endfunction

    // one item in flight per lane
    assign in_ready  = !s1_valid && !s2_valid;
    assign out_valid = s2_valid;
    assign out_span  = s2_span;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid && in_ready;
            if (s1_valid) begin
                s2_valid <= 1'b1;
            end else if (out_ready) begin
                s2_valid <= 1'b0;
            end
        end
    end

    // stage one, order the corners
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            s1_color <= in_cmd.color;
            s1_x0    <= ($signed(in_cmd.x0) <= $signed(in_cmd.x1)) ? in_cmd.x0 : in_cmd.x1;
            s1_x1    <= ($signed(in_cmd.x0) <= $signed(in_cmd.x1)) ? in_cmd.x1 : in_cmd.x0;
            s1_y0    <= ($signed(in_cmd.y0) <= $signed(in_cmd.y1)) ? in_cmd.y0 : in_cmd.y1;
            s1_y1    <= ($signed(in_cmd.y0) <= $signed(in_cmd.y1)) ? in_cmd.y1 : in_cmd.y0;
        end
    end

    // stage two, clamp and judge visibility
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_span.color   <= s1_color;
            s2_span.x0      <= x_w'(clamp(s1_x0, screen_w));
            s2_span.x1      <= x_w'(clamp(s1_x1, screen_w));
            s2_span.y0      <= y_w'(clamp(s1_y0, screen_h));
            s2_span.y1      <= y_w'(clamp(s1_y1, screen_h));
            s2_span.visible <= (s1_x1 >= 0) && (s1_x0 < screen_w) &&
                               (s1_y1 >= 0) && (s1_y0 < screen_h);
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_span));

endmodule

// File: src/vpu_collector.sv
module vpu_collector import vpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [num_lanes-1:0] lane_out_valid,
    output logic [num_lanes-1:0] lane_out_ready,
    input  vpu_span_t            lane_span [num_lanes],
    output logic                 span_req,
    output vpu_span_t            span,
    input  logic                 span_ack
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_release
    } req_state_e;

    req_state_e            state;
    logic [lane_idx_w-1:0] drain_ptr;
    vpu_span_t             head_span;
    logic                  head_valid;
    logic                  head_take;
    logic                  q_in_valid;
    logic                  q_in_ready;
    logic                  q_out_valid;
    logic                  q_out_ready;

    //////////////////////////////////////////////////////////////////////
    // in-order drain
    //////////////////////////////////////////////////////////////////////

    assign head_valid = lane_out_valid[drain_ptr];
    assign head_span  = lane_span[drain_ptr];
    // invisible spans are dropped here
    assign head_take  = !head_span.visible || q_in_ready;
    assign q_in_valid = head_valid && head_span.visible;

    always_comb begin
        lane_out_ready            = '0;
        lane_out_ready[drain_ptr] = head_take;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drain_ptr <= '0;
        end else if (head_valid && head_take) begin
            drain_ptr <= (drain_ptr == last_lane) ? '0 : drain_ptr + lane_idx_w'(1);
        end
    end

    vpu_queue #(
        .item_t (vpu_span_t),
        .depth  (queue_depth)
    ) u_span_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (q_in_valid),
        .in_ready  (q_in_ready),
        .in_item   (head_span),
        .out_valid (q_out_valid),
        .out_ready (q_out_ready),
        .out_item  (span)
    );

    //////////////////////////////////////////////////////////////////////
    // four-phase initiator
    //////////////////////////////////////////////////////////////////////

    // head leaves the queue once ack has dropped
    assign q_out_ready = (state == st_release) && !span_ack;
    assign span_req    = (state == st_req);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    if (q_out_valid && !span_ack) state <= st_req;
                st_req:     if (span_ack) state <= st_release;
                st_release: if (!span_ack) state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    a_span_stable: assert property (@(posedge clk) disable iff (!rst_n)
        span_req && $past(span_req) |-> $stable(span));

endmodule

// File: src/vpu_top.sv
module vpu_top import vpu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_req,
    input  vpu_cmd_t           cmd,
    output logic               cmd_ack,
    output logic [color_w-1:0] bg_color,
    output logic               span_req,
    output vpu_span_t          span,
    input  logic               span_ack
);

    logic [num_lanes-1:0] lane_in_valid;
    logic [num_lanes-1:0] lane_in_ready;
    logic [num_lanes-1:0] lane_out_valid;
    logic [num_lanes-1:0] lane_out_ready;
    vpu_cmd_t             lane_cmd;
    vpu_span_t            lane_span [num_lanes];

    vpu_cmd_intake u_intake (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_req       (cmd_req),
        .cmd           (cmd),
        .cmd_ack       (cmd_ack),
        .bg_color      (bg_color),
        .lane_in_valid (lane_in_valid),
        .lane_in_ready (lane_in_ready),
        .lane_cmd      (lane_cmd)
    );

    // lane_cmd is broadcast, valid picks the lane
    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        vpu_clip_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (lane_in_valid[i]),
            .in_ready  (lane_in_ready[i]),
            .in_cmd    (lane_cmd),
            .out_valid (lane_out_valid[i]),
            .out_ready (lane_out_ready[i]),
            .out_span  (lane_span[i])
        );
    end

    vpu_collector u_collector (
        .clk            (clk),
        .rst_n          (rst_n),
        .lane_out_valid (lane_out_valid),
        .lane_out_ready (lane_out_ready),
        .lane_span      (lane_span),
        .span_req       (span_req),
        .span           (span),
        .span_ack       (span_ack)
    );

endmodule

// File: bench/vpu_checker.sv
module vpu_checker import vpu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_ack,
    input  logic [color_w-1:0] bg_color,
    input  logic               span_req,
    input  vpu_span_t          span,
    input  logic               exp_push,
    input  vpu_span_t          exp_span,
    input  logic               fill_done,
    input  logic [color_w-1:0] fill_color,
    input  logic               end_of_test,
    output int                 pending,
    output int                 error_count,
    output logic               report_done
);

    vpu_span_t expect_q [$];
    vpu_span_t want;
    logic      in_reset;
    logic      span_req_q;
    int        span_count;
    int        fill_count;

    // one value against its expectation
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h at time %0t", name, got, exp, $time);
            error_count++;
        end
    endtask

    // a span offered on a rising span_req meets the oldest expectation
    task automatic check_span();
        if (expect_q.size() == 0) begin
            $display("unexpected span at time %0t, no more spans were expected", $time);
            error_count++;
        end else begin
            want = expect_q.pop_front();
            check_value("span.color", 32'(span.color), 32'(want.color));
            check_value("span.x0", 32'(span.x0), 32'(want.x0));
            check_value("span.x1", 32'(span.x1), 32'(want.x1));
            check_value("span.y0", 32'(span.y0), 32'(want.y0));
            check_value("span.y1", 32'(span.y1), 32'(want.y1));
            check_value("span.visible", 32'(span.visible), 32'(want.visible));
            span_count++;
        end
    endtask

    task automatic report_results();
        if (expect_q.size() != 0) begin
            $display("%0d expected spans never arrived", expect_q.size());
            error_count += expect_q.size();
        end
        $display("checker: %0d errors, %0d spans checked, %0d fills checked",
                 error_count, span_count, fill_count);
        report_done = 1'b1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // sampling on the rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst_n) begin
            expect_q.delete();
            in_reset    = 1'b1;
            span_req_q  = 1'b0;
            span_count  = 0;
            fill_count  = 0;
            error_count = 0;
            pending     <= 0;
            report_done = 1'b0;
        end else begin
            // port state straight after reset release
            if (in_reset) begin
                check_value("cmd_ack", 32'(cmd_ack), 32'd0);
                check_value("span_req", 32'(span_req), 32'd0);
                check_value("bg_color", 32'(bg_color), 32'd0);
            end
            in_reset = 1'b0;
            if (exp_push) begin
                expect_q.push_back(exp_span);
            end
            if (span_req && !span_req_q) begin
                check_span();
            end
            span_req_q = span_req;
            // bg_color was loaded on the ack edge and has long settled
            if (fill_done) begin
                check_value("bg_color", 32'(bg_color), 32'(fill_color));
                fill_count++;
            end
            if (end_of_test && !report_done) begin
                report_results();
            end
            pending <= expect_q.size();
        end
    end

endmodule

// File: bench/tb_vpu_top.sv
module tb_vpu_top import vpu_pkg::*; ();

    // one stimulus line, command plus the span it should give
    typedef struct packed {
        vpu_cmd_t  cmd;
        vpu_span_t want;
    } stim_t;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               cmd_req;
    vpu_cmd_t           cmd;
    logic               cmd_ack;
    logic [color_w-1:0] bg_color;
    logic               span_req;
    vpu_span_t          span;
    logic               span_ack;

    logic               exp_push;
    vpu_span_t          exp_span;
    logic               fill_done;
    logic [color_w-1:0] fill_color;
    logic               end_of_test;
    logic               report_done;
    logic               stim_loaded;
    int                 pending;
    int                 error_count;
    stim_t              stim_q [$];
    logic [31:0]        lfsr_state = 32'hdd5e;

    always #4 clk = ~clk;

    vpu_top vpu_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_req  (cmd_req),
        .cmd      (cmd),
        .cmd_ack  (cmd_ack),
        .bg_color (bg_color),
        .span_req (span_req),
        .span     (span),
        .span_ack (span_ack)
    );

    vpu_checker checker_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_ack     (cmd_ack),
        .bg_color    (bg_color),
        .span_req    (span_req),
        .span        (span),
        .exp_push    (exp_push),
        .exp_span    (exp_span),
        .fill_done   (fill_done),
        .fill_color  (fill_color),
        .end_of_test (end_of_test),
        .pending     (pending),
        .error_count (error_count),
        .report_done (report_done)
    );

    //////////////////////////////////////////////////////////////////////
    // stimulus file and random delays
    //////////////////////////////////////////////////////////////////////

    // lines that do not hold eleven numbers are skipped
    function automatic bit load_stimulus();
        int    fd;
        int    n;
        int    f [11];
        string line;
        stim_t s;
        fd = $fopen("bench/vpu_stimulus.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d", f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
            if (n == 11) begin
                s.cmd.op       = (f[0] != 0) ? op_fill : op_draw;
                s.cmd.color    = color_w'(f[1]);
                s.cmd.x0       = coord_w'(f[2]);
                s.cmd.y0       = coord_w'(f[3]);
                s.cmd.x1       = coord_w'(f[4]);
                s.cmd.y1       = coord_w'(f[5]);
                s.want.color   = color_w'(f[1]);
                s.want.visible = (f[6] != 0);
                s.want.x0      = x_w'(f[7]);
                s.want.x1      = x_w'(f[8]);
                s.want.y0      = y_w'(f[9]);
                s.want.y1      = y_w'(f[10]);
                stim_q.push_back(s);
            end
        end
        $fclose(fd);
        return stim_q.size() > 0;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // 0 to 7 cycles, three steps
    function automatic int ack_delay();
        int d;
        d = 0;
        for (int i = 0; i < 3; i++) begin
            d = (d << 1) | int'(lfsr_bit());
        end
        return d;
    endfunction

    // full four-phase cycle on the command port
    task automatic send_cmd(input stim_t s);
        @(posedge clk);
        cmd     <= s.cmd;
        cmd_req <= 1'b1;
        if (s.cmd.op == op_draw && s.want.visible) begin
            exp_span <= s.want;
            exp_push <= 1'b1;
        end
        @(posedge clk);
        exp_push <= 1'b0;
        while (!cmd_ack) begin
            @(posedge clk);
        end
        cmd_req <= 1'b0;
        if (s.cmd.op == op_fill) begin
            fill_color <= s.cmd.color;
            fill_done  <= 1'b1;
        end
        @(posedge clk);
        fill_done <= 1'b0;
        while (cmd_ack) begin
            @(posedge clk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // processes
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst_n       = 1'b0;
        cmd_req     = 1'b0;
        cmd         = '0;
        exp_push    = 1'b0;
        exp_span    = '0;
        fill_done   = 1'b0;
        fill_color  = '0;
        end_of_test = 1'b0;
        stim_loaded = 1'b0;
        if (load_stimulus()) begin
            stim_loaded = 1'b1;
            repeat (10) @(posedge clk);
            rst_n <= 1'b1;
            foreach (stim_q[i]) begin
                send_cmd(stim_q[i]);
            end
            // drain, then a quiet stretch to catch stray spans
            while (pending != 0) begin
                @(posedge clk);
            end
            repeat (20) @(posedge clk);
            end_of_test <= 1'b1;
            wait (report_done);
            if (error_count == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end else begin
            $display("could not read any command from bench/vpu_stimulus.txt");
            $display("TB FAILED");
            $finish;
        end
    end

    // rasterizer side, random ack delay per span
    initial begin
        span_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n && span_req) begin
                repeat (ack_delay()) @(posedge clk);
                span_ack <= 1'b1;
                @(posedge clk);
                while (span_req) begin
                    @(posedge clk);
                end
                span_ack <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        int limit;
        wait (stim_loaded);
        limit = stim_q.size() * 64 + 200;
        repeat (limit) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: bench/vpu_stimulus.txt
# op color x0 y0 x1 y1 | visible x0 x1 y0 y1 of the expected span
# op 0 is draw, op 1 is fill; fill and invisible rows keep zeros in the expected columns
1 5     0     0     0     0   0   0   0   0   0
1 2     0     0     0     0   0   0   0   0   0
0 3   300   200   100    50   1 100 300  50 200
0 6    10   400    20   300   1  10  20 300 400
0 1   -50   -20   100    60   1   0 100   0  60
0 7   600   470   900   700   1 600 639 470 479
0 4 -2000 -2000  2000  2000   1   0 639   0 479
0 2  -100    10    -1    50   0   0   0   0   0
0 5     0     0   639   479   1   0 639   0 479
0 3   640     0   700    10   0   0   0   0   0
0 6     0   480    10   500   0   0   0   0   0
0 7     5   -10     6  -300   0   0   0   0   0
1 6     0     0     0     0   0   0   0   0   0
0 1   639   479   639   479   1 639 639 479 479
0 2   320   240     0     0   1   0 320   0 240
0 3    50    -5    60     5   1  50  60   0   5
0 4     1     2     3     4   1   1   3   2   4
1 3     0     0     0     0   0   0   0   0   0
0 5   700   -40   -40   700   1   0 639   0 479
0 6   100   100   101   101   1 100 101 100 101
0 7  2047 -2048 -2048  2047   1   0 639   0 479
0 0   200   300   100   250   1 100 200 250 300
0 1    10    10    10    10   1  10  10  10  10
0 2   400   479   300   480   1 300 400 479 479
1 0     0     0     0     0   0   0   0   0   0
0 3   -10  -700   639   100   1   0 639   0 100
0 4   638     1   700     0   1 638 639   0   1
0 5    -1    -1    -1    -1   0   0   0   0   0
0 6    33    44    22    11   1  22  33  11  44
0 7   479   639   639   479   1 479 639 479 479

// File: vpu_top.f
src/vpu_pkg.sv
src/vpu_queue.sv
src/vpu_cmd_intake.sv
src/vpu_clip_lane.sv
src/vpu_collector.sv
src/vpu_top.sv
bench/vpu_checker.sv
bench/tb_vpu_top.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vpu_top.f --top-module tb_vpu_top -o sim_vpu_top \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_vpu_top > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"
